//--- build.f
+incdir+source
source/if_ctrl_pkg.sv
source/if_bus_pkg.sv
source/if_pc_select.sv
source/if_prefetch.sv
source/if_id_register.sv
source/if_stage.sv
tb/if_stage_checker.sv
tb/if_stage_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the instruction fetch stage

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= if_stage_tb
RTL_TOP   ?= if_stage
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tb/if_patterns.txt
// cmd operand stall first_pc count err_addr
// cmd 0 boot 1 jump 2 eret 3 dret 4 exc 5 irq 6 dbg halt 7 dbg exc 8 valid clear
0 00001000 0 00001080 00000006 FFFFFFFF
1 00004000 1 00004000 00000008 00004008
2 00005010 0 00005010 00000005 FFFFFFFF
3 00006020 1 00006020 00000005 00006024
4 00002001 0 00002000 00000004 FFFFFFFF
5 00000005 1 00002014 00000004 00002018
6 00000000 0 1A110800 00000003 FFFFFFFF
7 00000000 1 1A110808 00000003 1A11080C
8 00000000 0 00000000 00000000 FFFFFFFF
1 00007000 1 00007000 0000000C 00007010

//--- tb/if_stage_tb.sv
/*
 * fetch stage testbench
 * clock, reset, a req/gnt/rvalid memory model and pattern-driven redirects
 */

module if_stage_tb;

  import if_ctrl_pkg::*;
  import if_bus_pkg::*;

  localparam int NumTests = 10;
  localparam int Timeout  = 200;

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] boot_addr;
  logic        req;
  pc_ctrl_t    pc_ctrl;
  csr_pc_t     csr;
  logic [31:0] branch_target;
  logic        id_in_ready;
  logic        valid_clear;
  mem_rsp_t    mem_rsp;
  mem_req_t    mem_req;
  logic        instr_valid_id;
  logic        instr_new_id;
  if_id_t      if_id;
  logic [31:0] pc_if;
  logic        mtvec_init;
  logic        if_busy;
  logic        arm;
  logic [31:0] first_pc;
  logic [31:0] err_addr;
  int          rcv_cnt;
  int          chk_errs;
  logic [31:0] pat [0:NumTests*6-1];
  integer      seed;
  logic        stall_mode;
  logic        hold_low;
  logic        stall_now;
  logic        hold_now;
  logic        grant_seen;
  logic        req_wait;
  logic [31:0] grant_addr;
  int          delay;
  int          failed_tests;
  int          timeouts;

  if_stage u_dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .boot_addr_i(boot_addr), .req_i(req),
    .pc_ctrl_i(pc_ctrl), .csr_i(csr), .branch_target_i(branch_target),
    .id_in_ready_i(id_in_ready), .instr_valid_clear_i(valid_clear), .mem_rsp_i(mem_rsp),
    .mem_req_o(mem_req), .instr_valid_id_o(instr_valid_id), .instr_new_id_o(instr_new_id),
    .if_id_o(if_id), .pc_if_o(pc_if), .csr_mtvec_init_o(mtvec_init), .if_busy_o(if_busy)
  );

  if_stage_checker u_checker (
    .clk_i(clk_i), .rst_ni(rst_ni), .pc_ctrl_i(pc_ctrl), .instr_valid_clear_i(valid_clear),
    .instr_valid_id_i(instr_valid_id), .instr_new_id_i(instr_new_id), .if_id_i(if_id),
    .csr_mtvec_init_i(mtvec_init), .mem_req_i(mem_req), .mem_rsp_i(mem_rsp),
    .pc_if_i(pc_if), .if_busy_i(if_busy), .arm_i(arm), .first_pc_i(first_pc),
    .err_addr_i(err_addr), .rcv_cnt_o(rcv_cnt), .err_cnt_o(chk_errs)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////

  // note which request got granted at the coming edge
  always @(negedge clk_i) begin
    grant_seen = mem_req.req & mem_rsp.gnt;
    req_wait   = mem_req.req & ~mem_rsp.gnt;
    if (grant_seen) grant_addr = mem_req.addr;
    // decode stall controls for the next cycle
    stall_now = stall_mode;
    hold_now  = hold_low;
  end

  // rvalid one cycle after the grant, next grant after 0..2 cycles
  always @(posedge clk_i) begin
    #10;
    mem_rsp.rvalid = grant_seen;
    mem_rsp.rdata  = grant_seen ? (grant_addr ^ 32'hC0DE0000) : 32'b0;
    mem_rsp.err    = grant_seen && (grant_addr == err_addr);
    if (grant_seen) delay = ($random(seed) & 32'h7FFFFFFF) % 3;
    else if (req_wait && delay != 0) delay = delay - 1;
    mem_rsp.gnt = (delay == 0);
    // decode side back-pressure
    if (hold_now) id_in_ready = 1'b0;
    else if (stall_now) id_in_ready = 1'($random(seed));
    else id_in_ready = 1'b1;
  end

  task automatic step();
    @(posedge clk_i);
    #10;
  endtask

  // one pattern line: redirect or valid clear, then wait for the words
  task automatic run_test(input int idx);
    logic [31:0] cmd;
    logic [31:0] op;
    int          cnt;
    int          waited;
    int          errs_before;
    bit          ok;
    cmd         = pat[idx*6];
    op          = pat[idx*6+1];
    cnt         = pat[idx*6+4];
    errs_before = chk_errs;
    ok          = 1'b1;
    waited      = 0;
    if (cmd == 8) begin
      hold_low = 1'b1;
      step();
      step();
      valid_clear = 1'b1;
      step();
      valid_clear = 0;
      while (instr_valid_id && waited < Timeout) begin
        step();
        waited++;
      end
      hold_low = 1'b0;
    end else begin
      step();
      pc_ctrl = '{pc_set: 1'b1, pc_sel: PC_JUMP, exc_sel: EXC_PC_EXC, cause: '0};
      case (cmd)
        0: begin
          pc_ctrl.pc_sel = PC_BOOT;
          boot_addr      = op;
        end
        1: branch_target = op;
        2: begin
          pc_ctrl.pc_sel = PC_ERET;
          csr.mepc       = op;
        end
        3: begin
          pc_ctrl.pc_sel = PC_DRET;
          csr.depc       = op;
        end
        4: begin
          pc_ctrl.pc_sel = PC_EXC;
          csr.mtvec      = op;
        end
        5: begin
          pc_ctrl.pc_sel = PC_EXC;
          pc_ctrl.exc_sel = EXC_PC_IRQ;
          pc_ctrl.cause = '{irq: 1'b1, id: op[4:0]};
        end
        6: begin
          pc_ctrl.pc_sel  = PC_EXC;
          pc_ctrl.exc_sel = EXC_PC_DBD;
        end
        default: begin
          pc_ctrl.pc_sel  = PC_EXC;
          pc_ctrl.exc_sel = EXC_PC_DBG_EXC;
        end
      endcase
      // the core flushes decode together with every redirect
      valid_clear = 1'b1;
      req        = 1'b1;
      stall_mode = pat[idx*6+2][0];
      err_addr   = pat[idx*6+5];
      first_pc   = pat[idx*6+3];
      step();
      pc_ctrl.pc_set = 1'b0;
      valid_clear    = 1'b0;
      arm = 1'b1;
      step();
      arm = 1'b0;
      while (rcv_cnt < cnt && waited < Timeout) begin
        step();
        waited++;
      end
    end
    if (waited >= Timeout) begin
      $display("timeout: test %0d got no response within %0d cycles", idx, Timeout);
      timeouts++;
      ok = 1'b0;
    end
    if (chk_errs != errs_before) ok = 1'b0;
    if (!ok) failed_tests++;
    if (ok) begin
      $display("test %0d cmd %0d: %0d words, ok", idx, cmd, rcv_cnt);
    end else begin
      $display("test %0d cmd %0d: %0d words, failed", idx, cmd, rcv_cnt);
    end
  endtask

  initial begin
    seed          = 89;
    rst_ni        = 1'b0;
    boot_addr     = 32'b0;
    req           = 1'b0;
    pc_ctrl       = '0;
    csr           = '{mepc: 32'b0, depc: 32'b0, mtvec: 32'h00002001};
    branch_target = 32'b0;
    id_in_ready   = 1'b1;
    valid_clear   = 1'b0;
    mem_rsp       = '0;
    arm           = 1'b0;
    first_pc      = 32'b0;
    err_addr      = 32'hFFFFFFFF;
    stall_mode    = 1'b0;
    hold_low      = 1'b0;
    stall_now     = 1'b0;
    hold_now      = 1'b0;
    grant_seen    = 1'b0;
    req_wait      = 1'b0;
    grant_addr    = 32'b0;
    delay         = 0;
    failed_tests  = 0;
    timeouts      = 0;
    $readmemh("tb/if_patterns.txt", pat);
    repeat (5) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    for (int i = 0; i < NumTests; i++) begin
      run_test(i);
    end
    $display("tests %0d, failed %0d, check errors %0d, timeouts %0d",
             NumTests, failed_tests, chk_errs, timeouts);
    if (failed_tests == 0 && chk_errs == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- tb/if_stage_checker.sv
/*
 * fetch stage checker
 * follows the DUT outputs and compares pc, data, error, flags and bus behavior
 */

module if_stage_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  if_ctrl_pkg::pc_ctrl_t pc_ctrl_i,
  input  logic                  instr_valid_clear_i,
  input  logic                  instr_valid_id_i,
  input  logic                  instr_new_id_i,
  input  if_bus_pkg::if_id_t    if_id_i,
  input  logic                  csr_mtvec_init_i,
  input  if_bus_pkg::mem_req_t  mem_req_i,
  input  if_bus_pkg::mem_rsp_t  mem_rsp_i,
  input  logic [31:0]           pc_if_i,
  input  logic                  if_busy_i,
  input  logic                  arm_i,
  input  logic [31:0]           first_pc_i,
  input  logic [31:0]           err_addr_i,
  output int                    rcv_cnt_o,
  output int                    err_cnt_o
);

  import if_ctrl_pkg::*;

  logic [31:0] exp_pc;
  logic [31:0] err_addr;
  logic        armed;
  logic        pc_set_q;
  logic        clear_q;
  logic        valid_q;
  logic        exp_valid;
  logic        exp_init;
  logic [31:0] head_pc_q;
  logic [31:0] wait_addr;
  logic        wait_q;
  logic        gnt_q;
  logic        rvalid_q;
  logic        outstanding;

  initial begin
    rcv_cnt_o   = 0;
    err_cnt_o   = 0;
    armed       = 1'b0;
    pc_set_q    = 1'b0;
    clear_q     = 1'b0;
    valid_q     = 1'b0;
    exp_pc      = 32'b0;
    err_addr    = 32'hFFFFFFFF;
    head_pc_q   = 32'b0;
    wait_addr   = 32'b0;
    wait_q      = 1'b0;
    gnt_q       = 1'b0;
    rvalid_q    = 1'b0;
    outstanding = 1'b0;
  end

  // sample mid-cycle, all outputs settled
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      // everything idle while reset is held
      if (mem_req_i.req || instr_valid_id_i || instr_new_id_i || csr_mtvec_init_i ||
          if_busy_i) begin
        $display("FAIL t=%0t: outputs not low during reset", $time);
        err_cnt_o++;
      end
    end else begin
      if (arm_i) begin
        exp_pc    = first_pc_i;
        err_addr  = err_addr_i;
        rcv_cnt_o = 0;
        armed     = 1'b1;
      end

      // mtvec init only on the boot redirect
      exp_init = pc_ctrl_i.pc_set && (pc_ctrl_i.pc_sel == PC_BOOT);
      if (csr_mtvec_init_i !== exp_init) begin
        $display("FAIL t=%0t: mtvec init %b expected %b", $time, csr_mtvec_init_i, exp_init);
        err_cnt_o++;
      end

      // valid model: new word unless squashed, held until cleared
      exp_valid = (instr_new_id_i & ~pc_set_q) | (valid_q & ~clear_q);
      if (instr_valid_id_i !== exp_valid) begin
        $display("FAIL t=%0t: instr valid %b expected %b", $time, instr_valid_id_i,
                 exp_valid);
        err_cnt_o++;
      end
      pc_set_q = pc_ctrl_i.pc_set;
      clear_q  = instr_valid_clear_i;
      valid_q  = instr_valid_id_i;

      ////////////////////////////////////////////////////////////
      // instruction bus and busy
      ////////////////////////////////////////////////////////////
      // a granted request stays outstanding until its rvalid
      outstanding = gnt_q | (outstanding & ~rvalid_q);
      if (outstanding && !if_busy_i) begin
        $display("FAIL t=%0t: busy low with a request outstanding", $time);
        err_cnt_o++;
      end
      if (!outstanding && !mem_req_i.req && if_busy_i) begin
        $display("FAIL t=%0t: busy high on an idle bus", $time);
        err_cnt_o++;
      end
      // an ungranted request keeps req and addr
      if (wait_q && (!mem_req_i.req || mem_req_i.addr !== wait_addr)) begin
        $display("FAIL t=%0t: request withdrawn or moved before its grant", $time);
        err_cnt_o++;
      end
      gnt_q     = mem_req_i.req & mem_rsp_i.gnt;
      rvalid_q  = mem_rsp_i.rvalid;
      wait_q    = mem_req_i.req & ~mem_rsp_i.gnt;
      wait_addr = mem_req_i.addr;

      // the word taken last cycle came from the FIFO head
      if (instr_new_id_i && if_id_i.pc !== head_pc_q) begin
        $display("FAIL t=%0t: pc %h differs from head pc %h", $time, if_id_i.pc,
                 head_pc_q);
        err_cnt_o++;
      end
      head_pc_q = pc_if_i;

      ////////////////////////////////////////////////////////////
      // delivered words
      ////////////////////////////////////////////////////////////
      if (armed && instr_new_id_i && instr_valid_id_i) begin
        if (if_id_i.pc !== exp_pc) begin
          $display("FAIL t=%0t: pc %h expected %h", $time, if_id_i.pc, exp_pc);
          err_cnt_o++;
        end
        // data is the fetch address xor a fixed tag
        if (if_id_i.instr !== (exp_pc ^ 32'hC0DE0000)) begin
          $display("FAIL t=%0t: instr %h at pc %h expected %h", $time, if_id_i.instr,
                   exp_pc, exp_pc ^ 32'hC0DE0000);
          err_cnt_o++;
        end
        if (if_id_i.fetch_err !== (exp_pc == err_addr)) begin
          $display("FAIL t=%0t: fetch error %b at pc %h", $time, if_id_i.fetch_err, exp_pc);
          err_cnt_o++;
        end
        // resync on the observed pc so one slip is not reported over and over
        exp_pc = if_id_i.pc + 32'd4;
        rcv_cnt_o++;
      end
    end
  end

endmodule

//--- source/if_stage.sv
/*
 * instruction fetch stage
 * next-PC selection, prefetch over the instruction bus and the IF-ID register
 */

module if_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [31:0]           boot_addr_i,
  input  logic                  req_i,
  input  if_ctrl_pkg::pc_ctrl_t pc_ctrl_i,
  input  if_ctrl_pkg::csr_pc_t  csr_i,
  input  logic [31:0]           branch_target_i,
  input  logic                  id_in_ready_i,
  input  logic                  instr_valid_clear_i,
  input  if_bus_pkg::mem_rsp_t  mem_rsp_i,
  output if_bus_pkg::mem_req_t  mem_req_o,
  output logic                  instr_valid_id_o,
  output logic                  instr_new_id_o,
  output if_bus_pkg::if_id_t    if_id_o,
  output logic [31:0]           pc_if_o,
  output logic                  csr_mtvec_init_o,
  output logic                  if_busy_o
);

  import if_bus_pkg::*;

  logic [31:0]  fetch_addr_n;
  logic         branch_req;
  logic         fetch_valid;
  logic         fetch_ready;
  fetch_entry_t fetch_entry;

  // every redirect flushes the prefetch path
  assign branch_req = pc_ctrl_i.pc_set;

  if_pc_select u_pc_select (
    .boot_addr_i      (boot_addr_i),
    .pc_ctrl_i        (pc_ctrl_i),
    .csr_i            (csr_i),
    .branch_target_i  (branch_target_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_prefetch u_prefetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch_req),
    .branch_addr_i (fetch_addr_n),
    .fetch_ready_i (fetch_ready),
    .mem_rsp_i     (mem_rsp_i),
    .mem_req_o     (mem_req_o),
    .fetch_valid_o (fetch_valid),
    .fetch_entry_o (fetch_entry),
    .busy_o        (if_busy_o)
  );

  if_id_register u_id_register (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_entry_i       (fetch_entry),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_ctrl_i.pc_set),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .if_id_o             (if_id_o)
  );

  // pc of the word at the FIFO head
  assign pc_if_o = fetch_entry.addr;

endmodule

//--- source/if_id_register.sv
/*
 * IF-ID pipeline register
 * valid and new flags for the decode stage plus the instruction payload
 */

module if_id_register (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     fetch_valid_i,
  input  if_bus_pkg::fetch_entry_t fetch_entry_i,
  input  logic                     id_in_ready_i,
  input  logic                     pc_set_i,
  input  logic                     instr_valid_clear_i,
  output logic                     fetch_ready_o,
  output logic                     instr_valid_id_o,
  output logic                     instr_new_id_o,
  output if_bus_pkg::if_id_t       if_id_o
);

  import if_bus_pkg::*;

  logic transfer;
  logic valid_d;
  logic valid_q;
  logic new_q;

  // decode takes a word whenever it is ready
  assign fetch_ready_o = id_in_ready_i;
  assign transfer      = fetch_valid_i & fetch_ready_o;

  ////////////////////////////////////////////////////////////
  // flags
  ////////////////////////////////////////////////////////////

  // a word taken together with a redirect is squashed
  // otherwise valid holds until the core clears it
  assign valid_d = (transfer & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one pulse per accepted word, squashed or not
      new_q   <= transfer;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  // frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (transfer) begin
      if_id_o <= '{instr: fetch_entry_i.rdata,
                   pc: fetch_entry_i.addr,
                   fetch_err: fetch_entry_i.err};
    end
  end

endmodule

//--- source/if_prefetch.sv
/*
 * prefetch unit
 * drives the req/gnt/rvalid instruction bus with one request in flight,
 * drops stale responses after a redirect and buffers words in a small FIFO
 */

`include "if_settings.svh"

module if_prefetch (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     branch_i,
  input  logic [31:0]              branch_addr_i,
  input  logic                     fetch_ready_i,
  input  if_bus_pkg::mem_rsp_t     mem_rsp_i,
  output if_bus_pkg::mem_req_t     mem_req_o,
  output logic                     fetch_valid_o,
  output if_bus_pkg::fetch_entry_t fetch_entry_o,
  output logic                     busy_o
);

  import if_bus_pkg::*;

  localparam int unsigned Depth = `IF_FIFO_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  logic [31:0]     branch_addr;
  logic [31:0]     addr_q;
  logic [31:0]     rsp_addr_q;
  logic [31:0]     redir_addr_q;
  logic            hold_q;
  logic            redir_q;
  logic            out_q;
  logic            discard_q;
  logic            room;
  logic            issue;
  logic            grant;
  logic            stale_gnt;
  logic            push;
  logic            pop;
  logic [CntW-1:0] cnt_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  fetch_entry_t    fifo_q [Depth];

  // wrap-around pointer step, depth need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    logic [PtrW-1:0] nxt;
    nxt = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  // fetch is word aligned only
  assign branch_addr = {branch_addr_i[31:2], 2'b00};

  ////////////////////////////////////////////////////////////
  // request sequencing
  ////////////////////////////////////////////////////////////

  // FIFO slots left, the request in flight already owns one
  assign room = (32'(cnt_q) + 32'(out_q)) < Depth;

  // a waiting request stays up until granted
  // new ones wait out the redirect cycle so they carry the new address
  assign issue = hold_q |
                 (req_i & ~branch_i & room & (~out_q | mem_rsp_i.rvalid));
  assign grant = issue & mem_rsp_i.gnt;

  // granted while a redirect is pending means old path
  assign stale_gnt = grant & (branch_i | redir_q);

  assign mem_req_o.req  = issue;
  assign mem_req_o.addr = addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q    <= 32'b0;
      hold_q    <= 1'b0;
      redir_q   <= 1'b0;
      out_q     <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      // address moves on a grant or on a redirect with nothing waiting
      if (stale_gnt) begin
        addr_q <= branch_i ? branch_addr : redir_addr_q;
      end else if (grant) begin
        addr_q <= addr_q + 32'd4;
      end else if (branch_i && !hold_q) begin
        addr_q <= branch_addr;
      end
      hold_q  <= issue & ~mem_rsp_i.gnt;
      // redirect seen behind a waiting request is applied at its grant
      redir_q <= issue & ~mem_rsp_i.gnt & (redir_q | branch_i);
      out_q   <= grant | (out_q & ~mem_rsp_i.rvalid);
      if (grant) begin
        discard_q <= stale_gnt;
      end else if (out_q && !mem_rsp_i.rvalid) begin
        discard_q <= discard_q | branch_i;
      end else begin
        discard_q <= 1'b0;
      end
    end
  end

  // address of the request in flight and the deferred redirect target
  always_ff @(posedge clk_i) begin
    if (grant) begin
      rsp_addr_q <= addr_q;
    end
    if (branch_i) begin
      redir_addr_q <= branch_addr;
    end
  end

  ////////////////////////////////////////////////////////////
  // fetch FIFO
  ////////////////////////////////////////////////////////////

  // response arriving with a redirect is old path too
  assign push = out_q & mem_rsp_i.rvalid & ~discard_q & ~branch_i;
  assign pop  = fetch_valid_o & fetch_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else if (branch_i) begin
      // flush on redirect
      cnt_q    <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= '{addr: rsp_addr_q, rdata: mem_rsp_i.rdata, err: mem_rsp_i.err};
    end
  end

  assign fetch_valid_o = (cnt_q != '0);
  assign fetch_entry_o = fifo_q[rd_ptr_q];

  // busy while anything is on the bus
  assign busy_o = out_q | hold_q;

endmodule

//--- source/if_pc_select.sv
/*
 * next fetch address selection
 * exception vector mux plus the boot/jump/exception/return PC mux
 */

`include "if_settings.svh"

module if_pc_select (
  input  logic [31:0]           boot_addr_i,
  input  if_ctrl_pkg::pc_ctrl_t pc_ctrl_i,
  input  if_ctrl_pkg::csr_pc_t  csr_i,
  input  logic [31:0]           branch_target_i,
  output logic [31:0]           fetch_addr_n_o,
  output logic                  csr_mtvec_init_o
);

  import if_ctrl_pkg::*;

  localparam int unsigned VecBits = `IF_VEC_BITS;

  logic [31:0] vec_base;
  logic [31:0] irq_slot;
  logic [31:0] exc_pc;
  logic [31:0] boot_pc;

  ////////////////////////////////////////////////////////////
  // exception vector
  ////////////////////////////////////////////////////////////

  // handler base, mtvec with the low bits cleared
  assign vec_base = {csr_i.mtvec[31:VecBits], {VecBits{1'b0}}};

  // interrupts land 4 bytes per id above the base
  // synchronous exceptions always use the base itself
  assign irq_slot = pc_ctrl_i.cause.irq ? {25'b0, pc_ctrl_i.cause.id, 2'b00} : 32'b0;

  always_comb begin
    unique case (pc_ctrl_i.exc_sel)
      EXC_PC_EXC:     exc_pc = vec_base;
      EXC_PC_IRQ:     exc_pc = vec_base | irq_slot;
      EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:        exc_pc = vec_base;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // next fetch address
  ////////////////////////////////////////////////////////////

  // boot entry sits at a fixed offset inside the boot page
  assign boot_pc = {boot_addr_i[31:8], `IF_BOOT_OFFSET};

  always_comb begin
    unique case (pc_ctrl_i.pc_sel)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      PC_ERET: fetch_addr_n_o = csr_i.mepc;
      PC_DRET: fetch_addr_n_o = csr_i.depc;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // CSR file loads mtvec from the boot address on the boot redirect
  assign csr_mtvec_init_o = pc_ctrl_i.pc_set & (pc_ctrl_i.pc_sel == PC_BOOT);

endmodule

//--- source/if_bus_pkg.sv
/*
 * fetch datapath types
 * instruction memory request and response, fetch FIFO entry, IF-ID payload
 */

package if_bus_pkg;

  // request side, addr held stable while req waits for gnt
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } mem_req_t;

  // response side, err only counts together with rvalid
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } mem_rsp_t;

  // one fetched word with the address it came from
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
  } fetch_entry_t;

  // what the decode stage sees
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        fetch_err;
  } if_id_t;

endpackage

//--- source/if_ctrl_pkg.sv
/*
 * PC control types
 * next-PC selectors, exception cause and the redirect request from the core
 */

package if_ctrl_pkg;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of handler entered on PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // irq flag set for interrupts, id picks the vector slot
  typedef struct packed {
    logic       irq;
    logic [4:0] id;
  } exc_cause_t;

  // redirect request, only meaningful while pc_set is high
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_sel;
    exc_cause_t  cause;
  } pc_ctrl_t;

  // CSR values the fetch stage jumps to
  typedef struct packed {
    logic [31:0] mepc;
    logic [31:0] depc;
    logic [31:0] mtvec;
  } csr_pc_t;

endpackage

//--- source/if_settings.svh
/*
 * instruction fetch settings
 * fixed debug entry points, boot offset, vector alignment and fetch FIFO depth
 */

`ifndef IF_SETTINGS_SVH
`define IF_SETTINGS_SVH

// debug module entry on a halt request
`define IF_DM_HALT_ADDR 32'h1A110800

// debug module entry on an exception taken in debug mode
`define IF_DM_EXC_ADDR 32'h1A110808

// low byte placed under boot_addr[31:8] when leaving reset
`define IF_BOOT_OFFSET 8'h80

// mtvec bits below this index are replaced by the vector offset
`define IF_VEC_BITS 8

// fetch FIFO entries, the outstanding request counts as one of them
`define IF_FIFO_DEPTH 2

`endif
